//--- hw/core_mem_config.svh
`ifndef CORE_MEM_CONFIG_SVH
`define CORE_MEM_CONFIG_SVH

// word width of both memories and the core
`define DATA_WIDTH 32

// word address width, same for instr and data memory
`define MEM_ADDR_WIDTH 10

// words per memory
`define MEM_DEPTH (1 << `MEM_ADDR_WIDTH)

`endif

//--- hw/core_mem_pkg.sv
`include "core_mem_config.svh"

package core_mem_pkg;

  typedef logic [`DATA_WIDTH-1:0]     word_t;
  typedef logic [`DATA_WIDTH/8-1:0]   be_t;     // one bit per byte lane
  typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

  // opcode sits in instr[31:28], unknown codes run as NOP
  typedef enum logic [3:0] {
    NOP   = 4'd0,
    LOAD  = 4'd1,
    ADD   = 4'd2,
    STORE = 4'd3,
    JMP   = 4'd4,
    HALT  = 4'd15
  } opcode_t;

  // core sequencer
  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_INSTR,
    EXEC,
    WAIT_DATA,
    HALTED
  } core_state_t;

endpackage

//--- hw/mem_port_if.sv
`timescale 1ns/10ps

interface mem_port_if import core_mem_pkg::*; ();

  logic      req;
  logic      gnt;     // same cycle as req
  logic      rvalid;  // one cycle after the accepted req
  mem_addr_t addr;
  logic      we;
  be_t       be;
  word_t     wdata;
  word_t     rdata;

  // core or external bus side
  modport requester (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata
  );

  // arbiter side facing a requester
  modport responder (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata
  );

  // memory macro view, req acts as enable
  modport ram (
    input  req, addr, we, be, wdata,
    output rdata
  );

endinterface

//--- hw/sp_ram.sv
`timescale 1ns/10ps
`include "core_mem_config.svh"

module sp_ram (
  input logic clk,
  mem_port_if.ram ram
);

  logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (ram.req) begin
      if (ram.we) begin
        for (int i = 0; i < `DATA_WIDTH/8; i++) begin
          if (ram.be[i]) begin
            mem[ram.addr][i*8 +: 8] <= ram.wdata[i*8 +: 8];
          end
        end
      end
      // old contents on a write, nobody looks at it then
      ram.rdata <= mem[ram.addr];
    end
  end

  // catches a requester that raised enable before its address settled
  addr_known_a : assert property (
    @(posedge clk) ram.req |-> !$isunknown(ram.addr)
  ) else $error("sp_ram: unknown address with enable set");

endmodule

//--- hw/ram_mux.sv
`timescale 1ns/10ps

module ram_mux (
  input logic clk,
  input logic arst_n_i,
  mem_port_if.responder port0,  // external bus, always wins
  mem_port_if.responder port1,  // core
  mem_port_if.requester ram
);

  logic port1_sel;
  logic gnt0_q;  // port 0 owned the RAM last cycle
  logic gnt1_q;

  // fixed priority, port 1 only gets the RAM when port 0 is quiet
  assign port1_sel = ~port0.req;

  assign port0.gnt = port0.req;
  assign port1.gnt = port1.req & port1_sel;

  // forward the winner
  assign ram.req   = port0.req | port1.req;
  assign ram.addr  = port1_sel ? port1.addr  : port0.addr;
  assign ram.we    = port1_sel ? port1.we    : port0.we;
  assign ram.be    = port1_sel ? port1.be    : port0.be;
  assign ram.wdata = port1_sel ? port1.wdata : port0.wdata;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gnt0_q <= 1'b0;
      gnt1_q <= 1'b0;
    end else begin
      gnt0_q <= port0.gnt;
      gnt1_q <= port1.gnt;
    end
  end

  // RAM read data lines up with the registered grant
  assign port0.rvalid = gnt0_q;
  assign port1.rvalid = gnt1_q;
  assign port0.rdata  = gnt0_q ? ram.rdata : '0;
  assign port1.rdata  = gnt1_q ? ram.rdata : '0;

  one_gnt_a : assert property (
    @(posedge clk) disable iff (!arst_n_i) !(port0.gnt && port1.gnt)
  ) else $error("ram_mux: both ports granted");

  port0_rvalid_a : assert property (
    @(posedge clk) disable iff (!arst_n_i) port0.rvalid == $past(port0.gnt)
  ) else $error("ram_mux: port0 rvalid not one cycle after gnt");

  port1_rvalid_a : assert property (
    @(posedge clk) disable iff (!arst_n_i) port1.rvalid == $past(port1.gnt)
  ) else $error("ram_mux: port1 rvalid not one cycle after gnt");

endmodule

//--- hw/core.sv
`timescale 1ns/10ps
`include "core_mem_config.svh"

module core import core_mem_pkg::*; (
  input  logic clk,
  input  logic arst_n_i,
  input  logic core_en_i,
  mem_port_if.requester instr,
  mem_port_if.requester data,
  output logic halted_o
);

  core_state_t state_q;
  core_state_t state_d;
  logic        en_q;
  mem_addr_t   pc_q;
  word_t       ir_q;
  word_t       acc_q;
  opcode_t     op;
  mem_addr_t   operand;
  logic        mem_op;  // LOAD, ADD or STORE

  assign op      = opcode_t'(ir_q[31:28]);
  assign operand = ir_q[`MEM_ADDR_WIDTH-1:0];
  assign mem_op  = (op == LOAD) || (op == ADD) || (op == STORE);

  // instruction side, read only
  assign instr.req   = (state_q == FETCH);
  assign instr.addr  = pc_q;
  assign instr.we    = 1'b0;
  assign instr.be    = '0;
  assign instr.wdata = '0;

  // data side, request held in EXEC until granted
  assign data.req   = (state_q == EXEC) && mem_op;
  assign data.addr  = operand;
  assign data.we    = (op == STORE);
  assign data.be    = '1;
  assign data.wdata = acc_q;

  assign halted_o = (state_q == HALTED);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (en_q) state_d = FETCH;
      end
      FETCH: begin
        if (instr.gnt) state_d = WAIT_INSTR;
      end
      WAIT_INSTR: begin
        if (instr.rvalid) state_d = EXEC;
      end
      EXEC: begin
        if (op == HALT) begin
          state_d = HALTED;
        end else if (mem_op) begin
          if (data.gnt) state_d = WAIT_DATA;
        end else begin
          state_d = en_q ? FETCH : IDLE;
        end
      end
      WAIT_DATA: begin
        if (data.rvalid) state_d = en_q ? FETCH : IDLE;
      end
      HALTED: state_d = HALTED;  // only reset leaves
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      en_q    <= 1'b0;
      pc_q    <= '0;
      acc_q   <= '0;
    end else begin
      state_q <= state_d;
      en_q    <= core_en_i;
      if (state_q == EXEC) begin
        case (op)
          JMP:               pc_q <= operand;
          HALT, LOAD, ADD,
          STORE:             pc_q <= pc_q;  // halt keeps pc, mem ops step later
          default:           pc_q <= pc_q + 1'b1;
        endcase
      end
      if (state_q == WAIT_DATA && data.rvalid) begin
        pc_q <= pc_q + 1'b1;  // wraps at MEM_DEPTH
        if (op == LOAD) acc_q <= data.rdata;
        if (op == ADD)  acc_q <= acc_q + data.rdata;
      end
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state_q == WAIT_INSTR && instr.rvalid) begin
      ir_q <= instr.rdata;
    end
  end

  no_instr_write_a : assert property (
    @(posedge clk) disable iff (!arst_n_i) !instr.we
  ) else $error("core: write on instruction port");

  // data responses only come back to an outstanding access
  data_rvalid_a : assert property (
    @(posedge clk) disable iff (!arst_n_i) data.rvalid |-> state_q == WAIT_DATA
  ) else $error("core: unexpected data rvalid");

endmodule

//--- hw/top_core_mem.sv
`timescale 1ns/10ps

module top_core_mem import core_mem_pkg::*; (
  input  logic      clk,
  input  logic      arst_n_i,
  input  logic      core_en_i,

  // external bus to instr mem
  input  logic      ext_instr_req_i,
  input  mem_addr_t ext_instr_addr_i,
  input  logic      ext_instr_we_i,
  input  be_t       ext_instr_be_i,
  input  word_t     ext_instr_wdata_i,
  output logic      ext_instr_gnt_o,
  output logic      ext_instr_rvalid_o,
  output word_t     ext_instr_rdata_o,

  // external bus to data mem
  input  logic      ext_data_req_i,
  input  mem_addr_t ext_data_addr_i,
  input  logic      ext_data_we_i,
  input  be_t       ext_data_be_i,
  input  word_t     ext_data_wdata_i,
  output logic      ext_data_gnt_o,
  output logic      ext_data_rvalid_o,
  output word_t     ext_data_rdata_o,

  // core observation
  output mem_addr_t core_instr_addr_o,  // pc
  output mem_addr_t core_data_addr_o,
  output word_t     core_data_wdata_o,
  output logic      core_halted_o
);

  mem_port_if ext_instr_if ();
  mem_port_if ext_data_if ();
  mem_port_if core_instr_if ();
  mem_port_if core_data_if ();
  mem_port_if instr_ram_if ();  // mux to instr memory
  mem_port_if data_ram_if ();

  assign ext_instr_if.req   = ext_instr_req_i;
  assign ext_instr_if.addr  = ext_instr_addr_i;
  assign ext_instr_if.we    = ext_instr_we_i;
  assign ext_instr_if.be    = ext_instr_be_i;
  assign ext_instr_if.wdata = ext_instr_wdata_i;
  assign ext_instr_gnt_o    = ext_instr_if.gnt;
  assign ext_instr_rvalid_o = ext_instr_if.rvalid;
  assign ext_instr_rdata_o  = ext_instr_if.rdata;

  assign ext_data_if.req    = ext_data_req_i;
  assign ext_data_if.addr   = ext_data_addr_i;
  assign ext_data_if.we     = ext_data_we_i;
  assign ext_data_if.be     = ext_data_be_i;
  assign ext_data_if.wdata  = ext_data_wdata_i;
  assign ext_data_gnt_o     = ext_data_if.gnt;
  assign ext_data_rvalid_o  = ext_data_if.rvalid;
  assign ext_data_rdata_o   = ext_data_if.rdata;

  assign core_instr_addr_o  = core_instr_if.addr;
  assign core_data_addr_o   = core_data_if.addr;
  assign core_data_wdata_o  = core_data_if.wdata;

  core core_i (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .core_en_i (core_en_i),
    .instr     (core_instr_if),
    .data      (core_data_if),
    .halted_o  (core_halted_o)
  );

  // external bus on port 0 so it never waits
  ram_mux instr_ram_mux_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .port0    (ext_instr_if),
    .port1    (core_instr_if),
    .ram      (instr_ram_if)
  );

  ram_mux data_ram_mux_i (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .port0    (ext_data_if),
    .port1    (core_data_if),
    .ram      (data_ram_if)
  );

  sp_ram instr_mem (
    .clk (clk),
    .ram (instr_ram_if)
  );

  sp_ram data_mem (
    .clk (clk),
    .ram (data_ram_if)
  );

endmodule

//--- test/tb_top_core_mem.sv
`timescale 1ns/10ps
`include "core_mem_config.svh"

module tb_top_core_mem import core_mem_pkg::*; ();

  localparam int MAX_CYCLES = 4000;  // wide margin over the few hundred cycles of the tests
  localparam int HALT_LIMIT = 300;

  logic      clk;
  logic      arst_n_i;
  logic      core_en_i;
  logic      ext_instr_req_i, ext_instr_we_i;
  mem_addr_t ext_instr_addr_i;
  be_t       ext_instr_be_i;
  word_t     ext_instr_wdata_i;
  logic      ext_instr_gnt_o, ext_instr_rvalid_o;
  word_t     ext_instr_rdata_o;
  logic      ext_data_req_i, ext_data_we_i;
  mem_addr_t ext_data_addr_i;
  be_t       ext_data_be_i;
  word_t     ext_data_wdata_i;
  logic      ext_data_gnt_o, ext_data_rvalid_o;
  word_t     ext_data_rdata_o;
  mem_addr_t core_instr_addr_o, core_data_addr_o;
  word_t     core_data_wdata_o;
  logic      core_halted_o;

  integer    seed;
  int        cycle_cnt = 0;
  word_t     model [`MEM_DEPTH];  // expected memory contents

  top_core_mem dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) abort_run("timeout: the tests did not finish in time");
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // opcode in the top nibble and operand in the low address bits
  function automatic word_t encode_instr(input opcode_t op, input mem_addr_t operand);
    word_t w;
    w = '0;
    w[31:28] = op;
    w[`MEM_ADDR_WIDTH-1:0] = operand;
    return w;
  endfunction

  task automatic apply_reset();
    arst_n_i          = 1'b0;
    core_en_i         = 1'b0;
    ext_instr_req_i   = 1'b0;
    ext_instr_addr_i  = '0;
    ext_instr_we_i    = 1'b0;
    ext_instr_be_i    = '0;
    ext_instr_wdata_i = '0;
    ext_data_req_i    = 1'b0;
    ext_data_addr_i   = '0;
    ext_data_we_i     = 1'b0;
    ext_data_be_i     = '0;
    ext_data_wdata_i  = '0;
    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;
    @(negedge clk);
  endtask

  // starts at a falling edge and leaves req high, so calls can run back to back
  task automatic ext_access(input string name, input bit to_data, input mem_addr_t addr,
                            input logic we, input be_t be, input word_t wdata,
                            output word_t rdata);
    if (to_data) begin
      ext_data_req_i   = 1'b1;
      ext_data_addr_i  = addr;
      ext_data_we_i    = we;
      ext_data_be_i    = be;
      ext_data_wdata_i = wdata;
    end else begin
      ext_instr_req_i   = 1'b1;
      ext_instr_addr_i  = addr;
      ext_instr_we_i    = we;
      ext_instr_be_i    = be;
      ext_instr_wdata_i = wdata;
    end
    @(posedge clk);
    if ((to_data ? ext_data_gnt_o : ext_instr_gnt_o) !== 1'b1)
      abort_run($sformatf("%s: no gnt in the request cycle", name));
    @(negedge clk);
    if ((to_data ? ext_data_rvalid_o : ext_instr_rvalid_o) !== 1'b1)
      abort_run($sformatf("%s: no rvalid one cycle after the request", name));
    rdata = to_data ? ext_data_rdata_o : ext_instr_rdata_o;
  endtask

  task automatic release_bus();
    ext_instr_req_i = 1'b0;
    ext_data_req_i  = 1'b0;
  endtask

  task automatic wait_halt(input string name);
    int n = 0;
    while (core_halted_o !== 1'b1) begin
      if (n == HALT_LIMIT) abort_run($sformatf("%s: core never reached HALT", name));
      n++;
      @(negedge clk);
    end
  endtask

  task automatic test_reset_state();
    check("reset instr gnt", 0, ext_instr_gnt_o);
    check("reset instr rvalid", 0, ext_instr_rvalid_o);
    check("reset data gnt", 0, ext_data_gnt_o);
    check("reset data rvalid", 0, ext_data_rvalid_o);
    check("reset halted", 0, core_halted_o);
    check("reset pc", 0, core_instr_addr_o);
    check("reset acc", 0, core_data_wdata_o);  // store data is the accumulator
  endtask

  task automatic test_byte_enables();
    word_t rd;
    ext_access("byte_en full write", 1'b1, 10'd37, 1'b1, 4'b1111, 32'h1122_3344, rd);
    ext_access("byte_en partial write", 1'b1, 10'd37, 1'b1, 4'b0101, 32'haabb_ccdd, rd);
    ext_access("byte_en read", 1'b1, 10'd37, 1'b0, 4'b0000, '0, rd);
    release_bus();
    check("byte_en read", 32'h11bb_33dd, rd);  // lanes 0 and 2 from the second word
  endtask

  task automatic test_random_readback(input bit to_data);
    mem_addr_t addrs [16];
    word_t     rd;
    for (int i = 0; i < 16; i++) begin
      addrs[i] = mem_addr_t'($random(seed));
      model[addrs[i]] = word_t'($random(seed));
      ext_access("random write", to_data, addrs[i], 1'b1, '1, model[addrs[i]], rd);
    end
    for (int i = 0; i < 16; i++) begin
      ext_access("random read", to_data, addrs[i], 1'b0, '0, '0, rd);
      check(to_data ? "random data readback" : "random instr readback", model[addrs[i]], rd);
    end
    release_bus();
  endtask

  task automatic test_program_run();
    word_t a;
    word_t b;
    word_t rd;
    a = word_t'($random(seed));
    b = word_t'($random(seed));
    ext_access("load program", 1'b0, 10'd0, 1'b1, '1, encode_instr(LOAD, 10'd100), rd);
    ext_access("load program", 1'b0, 10'd1, 1'b1, '1, encode_instr(ADD, 10'd101), rd);
    ext_access("load program", 1'b0, 10'd2, 1'b1, '1, encode_instr(STORE, 10'd102), rd);
    ext_access("load program", 1'b0, 10'd3, 1'b1, '1, encode_instr(JMP, 10'd5), rd);
    ext_access("load program", 1'b0, 10'd4, 1'b1, '1, encode_instr(NOP, 10'd0), rd);
    ext_access("load program", 1'b0, 10'd5, 1'b1, '1, encode_instr(HALT, 10'd0), rd);
    release_bus();
    ext_access("load operand", 1'b1, 10'd100, 1'b1, '1, a, rd);
    ext_access("load operand", 1'b1, 10'd101, 1'b1, '1, b, rd);
    release_bus();
    core_en_i = 1'b1;
    wait_halt("program run");
    check("program run halt pc", 5, core_instr_addr_o);
    check("program run acc", a + b, core_data_wdata_o);
    ext_access("program run result", 1'b1, 10'd102, 1'b0, '0, '0, rd);
    release_bus();
    check("program run sum", a + b, rd);  // wraps at 32 bits
  endtask

  task automatic test_priority();
    word_t rd;
    word_t ld_val;
    apply_reset();  // the core only leaves HALTED through reset
    ld_val = word_t'($random(seed));
    ext_access("contention program", 1'b0, 10'd0, 1'b1, '1, encode_instr(LOAD, 10'd200), rd);
    ext_access("contention program", 1'b0, 10'd1, 1'b1, '1, encode_instr(JMP, 10'd0), rd);
    release_bus();
    ext_access("contention data", 1'b1, 10'd200, 1'b1, '1, ld_val, rd);
    for (int i = 0; i < 8; i++) begin
      model[300 + i] = word_t'($random(seed));
      ext_access("contention data", 1'b1, mem_addr_t'(300 + i), 1'b1, '1, model[300 + i], rd);
    end
    release_bus();
    core_en_i = 1'b1;
    repeat (6) @(negedge clk);  // let the loop get going
    for (int i = 0; i < 8; i++) begin
      ext_access("contention read", 1'b1, mem_addr_t'(300 + i), 1'b0, '0, '0, rd);
      check("contention read", model[300 + i], rd);
    end
    release_bus();
    // swap the jump for a halt so the loop ends
    // its operand field is ignored by HALT but still shows on the data address
    ext_access("contention patch", 1'b0, 10'd1, 1'b1, '1, encode_instr(HALT, 10'd250), rd);
    release_bus();
    wait_halt("contention");
    check("contention halt pc", 1, core_instr_addr_o);
    check("contention acc", ld_val, core_data_wdata_o);
    check("contention data addr", 250, core_data_addr_o);
  endtask

  initial begin
    seed = 32'h8273_6084;
    apply_reset();
    test_reset_state();
    test_byte_enables();
    test_random_readback(1'b0);
    test_random_readback(1'b1);
    test_program_run();
    test_priority();
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
hw/core_mem_pkg.sv
hw/mem_port_if.sv
hw/sp_ram.sv
hw/ram_mux.sv
hw/core.sv
hw/top_core_mem.sv
test/tb_top_core_mem.sv

//--- Bender.yml
package:
  name: core_mem

export_include_dirs:
  - hw

sources:
  - hw/core_mem_pkg.sv
  - hw/mem_port_if.sv
  - hw/sp_ram.sv
  - hw/ram_mux.sv
  - hw/core.sv
  - hw/top_core_mem.sv
  - target: test
    files:
      - test/tb_top_core_mem.sv
